//--- common/map_settings.svh
`ifndef MAP_SETTINGS_SVH
`define MAP_SETTINGS_SVH

// SDRAM byte address width
`define ADDR_BITS 23

// Fixed SDRAM regions above the game image
`define MENU_PRG_BASE 23'h7D_0000
`define MENU_CHR_BASE 23'h7D_8000
`define WRAM_BASE     23'h7E_0000

// Requests a channel may have in flight
`define MEM_CREDITS 4

// Host register map
`define REG_MAPPER 4'd0
`define REG_MENU   4'd1

`endif

//--- common/cart_pkg.sv
package cart_pkg;

    // Discrete boards handled by the game mapper
    typedef enum logic [1:0] {
        NROM  = 2'd0,
        UXROM = 2'd1,
        CNROM = 2'd2
    } mapper_kind_t;

    typedef enum logic {
        SLOT_MENU = 1'b0,
        SLOT_GAME = 1'b1
    } slot_t;

    // start_app sits in bit 0 to match the register layout
    typedef struct packed {
        logic ingame_menu;
        logic start_app;
    } menu_ctrl_t;

    // Console bus fields
    typedef logic [15:0] cpu_addr_t;
    typedef logic [13:0] ppu_addr_t;
    typedef logic [7:0]  bus_data_t;

endpackage

//--- common/sdram_pkg.sv
`include "map_settings.svh"

package sdram_pkg;

    typedef logic [`ADDR_BITS-1:0] sdram_addr_t;

    // PRG channel request
    typedef struct packed {
        sdram_addr_t addr;
        logic        we;
        logic [7:0]  wdata;
    } prg_req_t;

    // CHR channel request, kept apart from PRG so each can change alone
    typedef struct packed {
        sdram_addr_t addr;
        logic        we;
        logic [7:0]  wdata;
    } chr_req_t;

endpackage

//--- design/mem_port.sv
`timescale 1ns/1ps
`include "map_settings.svh"

module mem_port #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     cpu_reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,
    output logic     req_valid,
    output payload_t req_payload,
    input  logic     credit,
    input  logic     rvalid,
    input  logic [7:0] rdata,
    output logic [7:0] out_rdata,
    output logic     out_rvalid
);
    localparam int CNT_BITS = $clog2(`MEM_CREDITS + 1);

    logic [CNT_BITS-1:0] credits;
    logic                hold_valid;
    payload_t            hold_payload;
    logic                accept;
    logic                issue;
    payload_t            issue_payload;

    // Only one request can wait, so ready falls as soon as the buffer fills
    assign in_ready = !hold_valid;
    assign accept = in_valid && in_ready;

    // Held request goes first to keep order
    assign issue = (hold_valid || accept) && (credits != '0);
    assign issue_payload = hold_valid ? hold_payload : in_payload;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            credits <= CNT_BITS'(`MEM_CREDITS);
            hold_valid <= 1'b0;
            req_valid <= 1'b0;
            out_rvalid <= 1'b0;
        end else begin
            credits <= credits + CNT_BITS'(credit) - CNT_BITS'(issue);
            req_valid <= issue;
            out_rvalid <= rvalid;
            if (hold_valid) begin
                if (issue) begin
                    hold_valid <= 1'b0;
                end
            end else if (accept && !issue) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_payload <= issue_payload;
        end
        // Park it until a credit comes back
        if (accept && !issue) begin
            hold_payload <= in_payload;
        end
        if (rvalid) begin
            out_rdata <= rdata;
        end
    end

endmodule

//--- design/discrete_mapper.sv
`timescale 1ns/1ps
`include "map_settings.svh"

module discrete_mapper
    import cart_pkg::*;
(
    input  logic                  clk,
    input  logic                  cpu_reset,
    input  mapper_kind_t          kind,
    input  logic                  mirroring,
    input  logic                  active,
    input  logic                  cpu_fire,
    input  cpu_addr_t             cpu_addr,
    input  logic                  cpu_rw,
    input  bus_data_t             cpu_wdata,
    input  ppu_addr_t             ppu_addr,
    output logic [`ADDR_BITS-1:0] prg_offset,
    output logic                  wram_hit,
    output logic                  reg_write,
    output logic [`ADDR_BITS-1:0] chr_offset,
    output logic                  ciram_a10,
    output logic                  ciram_ce
);
    logic [3:0] prg_bank;
    logic [1:0] chr_bank;

    assign wram_hit = (cpu_addr[15:13] == 3'b011);

    // Any game write to ROM space is a bank register write
    assign reg_write = active && !cpu_rw && cpu_addr[15];

    always_ff @(posedge clk) begin
        if (cpu_reset || !active) begin
            prg_bank <= '0;
            chr_bank <= '0;
        end else if (cpu_fire && reg_write) begin
            case (kind)
                UXROM: prg_bank <= cpu_wdata[3:0];
                CNROM: chr_bank <= cpu_wdata[1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        prg_offset = `ADDR_BITS'(cpu_addr[14:0]);
        if (wram_hit) begin
            prg_offset = `ADDR_BITS'(cpu_addr[12:0]);
        end else if (kind == UXROM) begin
            if (cpu_addr[14]) begin
                // Fixed upper window, size mask trims it to the last bank
                prg_offset = {{(`ADDR_BITS - 14){1'b1}}, cpu_addr[13:0]};
            end else begin
                prg_offset = `ADDR_BITS'({prg_bank, cpu_addr[13:0]});
            end
        end
    end

    always_comb begin
        if (kind == CNROM) begin
            chr_offset = `ADDR_BITS'({chr_bank, ppu_addr[12:0]});
        end else begin
            chr_offset = `ADDR_BITS'(ppu_addr[12:0]);
        end
    end

    // Nametables 0x2000-0x3EFF, palettes stay inside the PPU
    assign ciram_ce = !(ppu_addr[13] && (ppu_addr[13:8] != 6'h3F));

    // Vertical mirroring when set, horizontal otherwise
    assign ciram_a10 = mirroring ? ppu_addr[10] : ppu_addr[11];

endmodule

//--- map_mux/map_control.sv
`timescale 1ns/1ps
`include "map_settings.svh"

module map_control
    import cart_pkg::*;
(
    input  logic         clk,
    input  logic         cpu_reset,
    input  logic [11:0]  wr_reg,
    input  logic [3:0]   wr_reg_addr,
    input  logic         wr_reg_changed,
    input  logic         cpu_fire,
    input  cpu_addr_t    cpu_addr,
    input  logic         cpu_rw,
    output slot_t        slot,
    output mapper_kind_t kind,
    output logic [4:0]   size_exp,
    output logic         mirroring,
    output menu_ctrl_t   menu_ctrl
);
    localparam cpu_addr_t NMI_VEC_LO   = 16'hFFFA;
    localparam cpu_addr_t NMI_VEC_HI   = 16'hFFFB;
    localparam cpu_addr_t RESET_VEC_LO = 16'hFFFC;

    logic [2:0] wr_sync;
    logic       host_write;
    logic       cpu_read;
    logic       hit_reset;
    logic       hit_nmi;
    logic       hit_nmi_done;
    slot_t      slot_q;

    // Host toggles wr_reg_changed once per write
    assign host_write = wr_sync[2] ^ wr_sync[1];

    assign cpu_read = cpu_fire && cpu_rw;
    assign hit_reset = menu_ctrl.start_app && cpu_read && (cpu_addr == RESET_VEC_LO);
    assign hit_nmi = menu_ctrl.ingame_menu && cpu_read && (cpu_addr == NMI_VEC_LO);
    assign hit_nmi_done = menu_ctrl.ingame_menu && cpu_read && (cpu_addr == NMI_VEC_HI);

    // Vector fetch must already see the new slot
    assign slot = hit_reset ? SLOT_GAME : (hit_nmi ? SLOT_MENU : slot_q);

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            wr_sync <= '0;
            slot_q <= SLOT_MENU;
            kind <= NROM;
            size_exp <= '0;
            mirroring <= 1'b0;
            menu_ctrl <= '0;
        end else begin
            wr_sync <= {wr_sync[1:0], wr_reg_changed};

            if (host_write) begin
                case (wr_reg_addr)
                    `REG_MAPPER: begin
                        kind <= mapper_kind_t'(wr_reg[1:0]);
                        size_exp <= wr_reg[6:2];
                        mirroring <= wr_reg[7];
                    end
                    `REG_MENU: begin
                        menu_ctrl <= menu_ctrl_t'(wr_reg[1:0]);
                    end
                    default: ;
                endcase
            end

            // Launch the game on its reset vector
            if (hit_reset) begin
                slot_q <= SLOT_GAME;
                menu_ctrl.start_app <= 1'b0;
            end

            // NMI vector takes the console back to the menu
            if (hit_nmi) begin
                slot_q <= SLOT_MENU;
            end
            if (hit_nmi_done) begin
                menu_ctrl.ingame_menu <= 1'b0;
            end
        end
    end

endmodule

//--- map_mux/map_mux.sv
`timescale 1ns/1ps
`include "map_settings.svh"

module map_mux
    import cart_pkg::*;
    import sdram_pkg::*;
(
    input  logic                  clk,
    input  logic                  cpu_reset,

    input  logic                  cpu_req,
    input  cpu_addr_t             cpu_addr,
    input  logic                  cpu_rw,
    input  bus_data_t             cpu_wdata,
    output logic                  cpu_ready,
    output bus_data_t             cpu_rdata,
    output logic                  cpu_rvalid,

    input  logic                  ppu_req,
    input  ppu_addr_t             ppu_addr,
    input  logic                  ppu_rw,
    input  bus_data_t             ppu_wdata,
    output logic                  ppu_ready,
    output bus_data_t             ppu_rdata,
    output logic                  ppu_rvalid,
    output logic                  ppu_ciram_a10,
    output logic                  ppu_ciram_ce,

    input  logic [11:0]           wr_reg,
    input  logic [3:0]            wr_reg_addr,
    input  logic                  wr_reg_changed,
    output logic [15:0]           status_reg,

    output logic                  prg_req_valid,
    output logic [`ADDR_BITS-1:0] prg_req_addr,
    output logic                  prg_req_we,
    output logic [7:0]            prg_req_wdata,
    input  logic                  prg_credit,
    input  logic                  prg_rvalid,
    input  logic [7:0]            prg_rdata,

    output logic                  chr_req_valid,
    output logic [`ADDR_BITS-1:0] chr_req_addr,
    output logic                  chr_req_we,
    output logic [7:0]            chr_req_wdata,
    input  logic                  chr_credit,
    input  logic                  chr_rvalid,
    input  logic [7:0]            chr_rdata
);
    slot_t                 slot;
    mapper_kind_t          kind;
    logic [4:0]            size_exp;
    logic                  mirroring;
    menu_ctrl_t            menu_ctrl;

    logic                  cpu_fire;
    logic                  ppu_fire;
    logic [`ADDR_BITS-1:0] prg_offset;
    logic [`ADDR_BITS-1:0] chr_offset;
    logic                  wram_hit;
    logic                  reg_write;
    logic [`ADDR_BITS-1:0] size_bit;
    logic [`ADDR_BITS-1:0] prg_mask;

    prg_req_t              prg_in;
    prg_req_t              prg_out;
    chr_req_t              chr_in;
    chr_req_t              chr_out;

    assign cpu_fire = cpu_req && cpu_ready;
    assign ppu_fire = ppu_req && ppu_ready;

    map_control u_control (
        .clk            (clk),
        .cpu_reset      (cpu_reset),
        .wr_reg         (wr_reg),
        .wr_reg_addr    (wr_reg_addr),
        .wr_reg_changed (wr_reg_changed),
        .cpu_fire       (cpu_fire),
        .cpu_addr       (cpu_addr),
        .cpu_rw         (cpu_rw),
        .slot           (slot),
        .kind           (kind),
        .size_exp       (size_exp),
        .mirroring      (mirroring),
        .menu_ctrl      (menu_ctrl)
    );

    discrete_mapper u_mapper (
        .clk        (clk),
        .cpu_reset  (cpu_reset),
        .kind       (kind),
        .mirroring  (mirroring),
        .active     (slot == SLOT_GAME),
        .cpu_fire   (cpu_fire),
        .cpu_addr   (cpu_addr),
        .cpu_rw     (cpu_rw),
        .cpu_wdata  (cpu_wdata),
        .ppu_addr   (ppu_addr),
        .prg_offset (prg_offset),
        .wram_hit   (wram_hit),
        .reg_write  (reg_write),
        .chr_offset (chr_offset),
        .ciram_a10  (ppu_ciram_a10),
        .ciram_ce   (ppu_ciram_ce)
    );

    // Game image is PRG at zero with CHR right above it
    assign size_bit = `ADDR_BITS'(1) << size_exp;
    assign prg_mask = size_bit - 1'b1;

    always_comb begin
        prg_in.we = !cpu_rw;
        prg_in.wdata = cpu_wdata;
        if (wram_hit) begin
            prg_in.addr = `WRAM_BASE | prg_offset;
        end else if (slot == SLOT_MENU) begin
            prg_in.addr = `MENU_PRG_BASE | `ADDR_BITS'(cpu_addr[14:0]);
        end else begin
            prg_in.addr = prg_offset & prg_mask;
        end
    end

    always_comb begin
        chr_in.we = !ppu_rw;
        chr_in.wdata = ppu_wdata;
        if (slot == SLOT_MENU) begin
            chr_in.addr = `MENU_CHR_BASE | `ADDR_BITS'(ppu_addr[12:0]);
        end else begin
            chr_in.addr = chr_offset | size_bit;
        end
    end

    // Bank writes stop at the mapper
    mem_port #(
        .payload_t (prg_req_t)
    ) u_prg_port (
        .clk         (clk),
        .cpu_reset   (cpu_reset),
        .in_valid    (cpu_fire && !reg_write),
        .in_payload  (prg_in),
        .in_ready    (cpu_ready),
        .req_valid   (prg_req_valid),
        .req_payload (prg_out),
        .credit      (prg_credit),
        .rvalid      (prg_rvalid),
        .rdata       (prg_rdata),
        .out_rdata   (cpu_rdata),
        .out_rvalid  (cpu_rvalid)
    );

    mem_port #(
        .payload_t (chr_req_t)
    ) u_chr_port (
        .clk         (clk),
        .cpu_reset   (cpu_reset),
        .in_valid    (ppu_fire),
        .in_payload  (chr_in),
        .in_ready    (ppu_ready),
        .req_valid   (chr_req_valid),
        .req_payload (chr_out),
        .credit      (chr_credit),
        .rvalid      (chr_rvalid),
        .rdata       (chr_rdata),
        .out_rdata   (ppu_rdata),
        .out_rvalid  (ppu_rvalid)
    );

    assign prg_req_addr = prg_out.addr;
    assign prg_req_we = prg_out.we;
    assign prg_req_wdata = prg_out.wdata;

    assign chr_req_addr = chr_out.addr;
    assign chr_req_we = chr_out.we;
    assign chr_req_wdata = chr_out.wdata;

    // bit 0 slot, 2:1 menu flags, 4:3 kind, 9:5 size, 10 mirroring
    assign status_reg = {5'd0, mirroring, size_exp, kind, menu_ctrl, slot};

endmodule

//--- dv/map_mux_tb.sv
`timescale 1ns/1ps
`include "map_settings.svh"

// SDRAM controller model for one channel with in-order reads
module sdram_model (
    input  logic                  clk,
    input  logic                  cpu_reset,
    input  logic                  withhold,
    input  logic                  req_valid,
    input  logic [`ADDR_BITS-1:0] req_addr,
    input  logic                  req_we,
    input  logic [7:0]            req_wdata,
    output logic                  credit,
    output logic                  rvalid,
    output logic [7:0]            rdata,
    output int                    errors
);
    integer                seed;
    int                    cycle;
    int                    outstanding;
    int                    last_rd;
    int                    last_cr;
    int                    t;
    int                    rd_time[$];
    logic [`ADDR_BITS-1:0] rd_addr[$];
    int                    cr_time[$];
    logic [7:0]            wmem[int];
    logic [`ADDR_BITS-1:0] a;

    initial begin
        seed = 56;
        errors = 0;
    end

    always @(posedge clk) begin
        if (cpu_reset) begin
            credit <= 1'b0;
            rvalid <= 1'b0;
            cycle = 0;
            outstanding = 0;
            last_rd = 0;
            last_cr = 0;
            rd_time.delete();
            rd_addr.delete();
            cr_time.delete();
        end else begin
            cycle++;
            credit <= 1'b0;
            rvalid <= 1'b0;
            if (req_valid) begin
                outstanding++;
                if (req_we) begin
                    wmem[req_addr] = req_wdata;
                end else begin
                    t = cycle + 1 + int'($unsigned($random(seed)) % 6);
                    if (t > last_rd) last_rd = t;
                    rd_time.push_back(last_rd);
                    rd_addr.push_back(req_addr);
                end
                t = cycle + 1 + int'($unsigned($random(seed)) % 8);
                if (t > last_cr) last_cr = t;
                cr_time.push_back(last_cr);
            end
            if (rd_time.size() > 0 && rd_time[0] <= cycle) begin
                void'(rd_time.pop_front());
                a = rd_addr.pop_front();
                rvalid <= 1'b1;
                rdata <= wmem.exists(a) ? wmem[a] : (a[7:0] ^ a[15:8]);
            end
            // Credits held back to stall the port
            if (!withhold && cr_time.size() > 0 && cr_time[0] <= cycle) begin
                void'(cr_time.pop_front());
                credit <= 1'b1;
                outstanding--;
            end
            assert (outstanding <= `MEM_CREDITS) else begin
                $display("More SDRAM requests outstanding than credits allow");
                errors++;
            end
        end
    end
endmodule

module map_mux_tb;
    localparam int MAX_CYCLES = 20000;
    localparam int REQ_BITS = `ADDR_BITS + 9;

    logic clk = 1'b0;
    logic cpu_reset;
    logic cpu_req, cpu_rw, cpu_ready, cpu_rvalid;
    logic [15:0] cpu_addr;
    logic [7:0] cpu_wdata, cpu_rdata;
    logic ppu_req, ppu_rw, ppu_ready, ppu_rvalid, ppu_ciram_a10, ppu_ciram_ce;
    logic [13:0] ppu_addr;
    logic [7:0] ppu_wdata, ppu_rdata;
    logic [11:0] wr_reg;
    logic [3:0] wr_reg_addr;
    logic wr_reg_changed;
    logic [15:0] status_reg;
    logic prg_req_valid, prg_req_we, prg_credit, prg_rvalid;
    logic [`ADDR_BITS-1:0] prg_req_addr, chr_req_addr;
    logic [7:0] prg_req_wdata, prg_rdata, chr_req_wdata, chr_rdata;
    logic chr_req_valid, chr_req_we, chr_credit, chr_rvalid;
    logic withhold;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int prg_errors, chr_errors;
    bit ready_dropped = 0;
    // Each entry holds {we, wdata, addr}
    logic [REQ_BITS-1:0] exp_prg[$];
    logic [REQ_BITS-1:0] exp_chr[$];
    logic [REQ_BITS-1:0] prg_exp;
    logic [REQ_BITS-1:0] chr_exp;
    logic [7:0] exp_cpu[$];
    logic [7:0] exp_ppu[$];
    logic [7:0] ref_mem[int];

    always #5 clk = ~clk;

    map_mux DUT (.*);

    sdram_model u_prg_model (
        .clk(clk), .cpu_reset(cpu_reset), .withhold(withhold),
        .req_valid(prg_req_valid), .req_addr(prg_req_addr), .req_we(prg_req_we),
        .req_wdata(prg_req_wdata), .credit(prg_credit), .rvalid(prg_rvalid),
        .rdata(prg_rdata), .errors(prg_errors)
    );

    sdram_model u_chr_model (
        .clk(clk), .cpu_reset(cpu_reset), .withhold(1'b0),
        .req_valid(chr_req_valid), .req_addr(chr_req_addr), .req_we(chr_req_we),
        .req_wdata(chr_req_wdata), .credit(chr_credit), .rvalid(chr_rvalid),
        .rdata(chr_rdata), .errors(chr_errors)
    );

    function automatic logic [7:0] expected_byte(logic [`ADDR_BITS-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : (a[7:0] ^ a[15:8]);
    endfunction

    // UxROM address with the last bank fixed at 0xC000
    function automatic logic [`ADDR_BITS-1:0] uxrom_addr(logic [15:0] a, int bank, int s);
        logic [`ADDR_BITS-1:0] full;
        logic [`ADDR_BITS-1:0] last_bank;
        last_bank = (`ADDR_BITS'(1) << s) - `ADDR_BITS'(16384);
        full = a[14] ? last_bank + `ADDR_BITS'(a[13:0])
                     : `ADDR_BITS'(bank * 16384 + a[13:0]);
        return full & ((`ADDR_BITS'(1) << s) - 1);
    endfunction

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic cpu_access(logic [15:0] a, logic rw, logic [7:0] wd, bit fwd,
                              logic [`ADDR_BITS-1:0] ea);
        @(posedge clk);
        cpu_req <= 1'b1;
        cpu_addr <= a;
        cpu_rw <= rw;
        cpu_wdata <= wd;
        do @(posedge clk); while (!cpu_ready);
        if (fwd) exp_prg.push_back({!rw, wd, ea});
        if (rw) exp_cpu.push_back(expected_byte(ea));
        else if (fwd) ref_mem[ea] = wd;
        cpu_req <= 1'b0;
    endtask

    task automatic ppu_access(logic [13:0] a, logic rw, logic [7:0] wd,
                              logic [`ADDR_BITS-1:0] ea);
        @(posedge clk);
        ppu_req <= 1'b1;
        ppu_addr <= a;
        ppu_rw <= rw;
        ppu_wdata <= wd;
        do @(posedge clk); while (!ppu_ready);
        exp_chr.push_back({!rw, wd, ea});
        if (rw) exp_ppu.push_back(expected_byte(ea));
        else ref_mem[ea] = wd;
        ppu_req <= 1'b0;
    endtask

    task automatic host_write(logic [3:0] ra, logic [11:0] v);
        @(posedge clk);
        wr_reg <= v;
        wr_reg_addr <= ra;
        wr_reg_changed <= ~wr_reg_changed;
        repeat (5) @(posedge clk);
    endtask

    task automatic nametable_check(logic [13:0] a, logic mirr);
        @(posedge clk);
        ppu_addr <= a;
        @(posedge clk);
        check_eq("ppu_ciram_a10", ppu_ciram_a10, mirr ? a[10] : a[11]);
        check_eq("ppu_ciram_ce", ppu_ciram_ce, !(a >= 14'h2000 && a < 14'h3F00));
    endtask

    task automatic drain();
        while (exp_prg.size() || exp_chr.size() || exp_cpu.size() || exp_ppu.size())
            @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // Requests and read returns matched in order
    always @(posedge clk) begin
        if (!cpu_reset) begin
            if (!cpu_ready) ready_dropped = 1;
            if (prg_req_valid) begin
                if (exp_prg.size() == 0) begin
                    $display("Unexpected PRG request to address %h", prg_req_addr);
                    errors++;
                end else begin
                    prg_exp = exp_prg.pop_front();
                    check_eq("prg_req_addr", prg_req_addr, prg_exp[`ADDR_BITS-1:0]);
                    check_eq("prg_req_we", prg_req_we, prg_exp[REQ_BITS-1]);
                    if (prg_exp[REQ_BITS-1])
                        check_eq("prg_req_wdata", prg_req_wdata,
                                 prg_exp[REQ_BITS-2:`ADDR_BITS]);
                end
            end
            if (chr_req_valid) begin
                if (exp_chr.size() == 0) begin
                    $display("Unexpected CHR request to address %h", chr_req_addr);
                    errors++;
                end else begin
                    chr_exp = exp_chr.pop_front();
                    check_eq("chr_req_addr", chr_req_addr, chr_exp[`ADDR_BITS-1:0]);
                    check_eq("chr_req_we", chr_req_we, chr_exp[REQ_BITS-1]);
                    if (chr_exp[REQ_BITS-1])
                        check_eq("chr_req_wdata", chr_req_wdata,
                                 chr_exp[REQ_BITS-2:`ADDR_BITS]);
                end
            end
            if (cpu_rvalid) begin
                if (exp_cpu.size() == 0) begin
                    $display("CPU read data returned with no read pending");
                    errors++;
                end else check_eq("cpu_rdata", cpu_rdata, exp_cpu.pop_front());
            end
            if (ppu_rvalid) begin
                if (exp_ppu.size() == 0) begin
                    $display("PPU read data returned with no read pending");
                    errors++;
                end else check_eq("ppu_rdata", ppu_rdata, exp_ppu.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with reads still pending", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        cpu_reset = 1'b1;
        {cpu_req, cpu_rw, cpu_addr, cpu_wdata} = '0;
        {ppu_req, ppu_rw, ppu_addr, ppu_wdata} = '0;
        {wr_reg, wr_reg_addr, wr_reg_changed} = '0;
        withhold = 1'b0;
        ppu_rw = 1'b1;
        repeat (16) @(posedge clk);
        cpu_reset <= 1'b0;
        @(posedge clk);
        check_eq("cpu_ready", cpu_ready, 1);
        check_eq("ppu_ready", ppu_ready, 1);
        check_eq("prg_req_valid", prg_req_valid, 0);
        check_eq("status_reg", status_reg, 16'h0000);

        // Menu window
        cpu_access(16'h8123, 1, 0, 1, `MENU_PRG_BASE + 23'h0123);
        cpu_access(16'hC456, 1, 0, 1, `MENU_PRG_BASE + 23'h4456);
        ppu_access(14'h0456, 1, 0, `MENU_CHR_BASE + 23'h0456);
        drain();

        // UxROM with 128 KB PRG launched through the reset vector
        host_write(`REG_MAPPER, 12'h0C5);
        check_eq("status_reg.kind", status_reg[4:3], 1);
        host_write(`REG_MENU, 12'h001);
        cpu_access(16'hFFFC, 1, 0, 1, uxrom_addr(16'hFFFC, 0, 17));
        drain();
        check_eq("status_reg.slot", status_reg[0], 1);
        check_eq("status_reg.start_app", status_reg[1], 0);
        cpu_access(16'h8000, 0, 8'h03, 0, 0);
        cpu_access(16'h8010, 1, 0, 1, uxrom_addr(16'h8010, 3, 17));
        cpu_access(16'hC020, 1, 0, 1, uxrom_addr(16'hC020, 3, 17));
        cpu_access(16'h8000, 0, 8'h09, 0, 0);
        cpu_access(16'hA345, 1, 0, 1, uxrom_addr(16'hA345, 9, 17));
        drain();

        // CNROM with 32 KB PRG and CHR bank 2
        host_write(`REG_MAPPER, 12'h03E);
        cpu_access(16'h8000, 0, 8'h02, 0, 0);
        ppu_access(14'h0123, 1, 0, 23'h8000 + 2 * 8192 + 23'h0123);
        ppu_access(14'h0200, 0, 8'h5A, 23'h8000 + 2 * 8192 + 23'h0200);
        ppu_access(14'h0200, 1, 0, 23'h8000 + 2 * 8192 + 23'h0200);
        drain();

        // Work RAM write and read back
        cpu_access(16'h6010, 0, 8'hA5, 1, `WRAM_BASE + 23'h0010);
        cpu_access(16'h6010, 1, 0, 1, `WRAM_BASE + 23'h0010);
        cpu_access(16'h7FFF, 1, 0, 1, `WRAM_BASE + 23'h1FFF);
        drain();
        nametable_check(14'h2C00, 0);
        nametable_check(14'h2400, 0);
        host_write(`REG_MAPPER, 12'h0BE);
        nametable_check(14'h2400, 1);
        nametable_check(14'h2800, 1);
        nametable_check(14'h1000, 1);
        nametable_check(14'h3F00, 1);

        // In-game menu through the NMI vector
        host_write(`REG_MENU, 12'h002);
        cpu_access(16'hFFFA, 1, 0, 1, `MENU_PRG_BASE + 23'h7FFA);
        cpu_access(16'hFFFB, 1, 0, 1, `MENU_PRG_BASE + 23'h7FFB);
        drain();
        check_eq("status_reg.slot", status_reg[0], 0);
        check_eq("status_reg.ingame_menu", status_reg[2], 0);
        cpu_access(16'h8100, 1, 0, 1, `MENU_PRG_BASE + 23'h0100);
        drain();

        // Credit starvation
        ready_dropped = 0;
        withhold <= 1'b1;
        fork
            begin
                repeat (60) @(posedge clk);
                withhold <= 1'b0;
            end
        join_none
        for (int i = 0; i < 8; i++)
            cpu_access(16'h8200 + 16'(i), 1, 0, 1, `MENU_PRG_BASE + 23'h0200 + 23'(i));
        drain();
        checks++;
        assert (ready_dropped) else begin
            $display("cpu_ready never dropped while credits were withheld");
            errors++;
        end

        errors += prg_errors + chr_errors;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

//--- vlog.f
+incdir+common
common/cart_pkg.sv
common/sdram_pkg.sv
design/mem_port.sv
design/discrete_mapper.sv
map_mux/map_control.sv
map_mux/map_mux.sv
dv/map_mux_tb.sv

//--- Bender.yml
package:
  name: map_mux

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cart_pkg.sv
      - common/sdram_pkg.sv
      - design/mem_port.sv
      - design/discrete_mapper.sv
      - map_mux/map_control.sv
      - map_mux/map_mux.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/map_mux_tb.sv
